// File: rtl/mask_pkg.sv
`default_nettype none

package mask_pkg;

	// ------------------------------------------------------------------------
	// Bus widths
	// ------------------------------------------------------------------------

	// Data width on both the slave and the master port
	localparam int DATA_W = 32;
	// One strobe bit per data byte
	localparam int STRB_W = DATA_W / 8;
	// Slave address covers four 32-bit registers
	localparam int S_ADDR_W = 4;
	// Lowest address bit used for register select
	localparam int ADDR_LSB = 2;
	// Mask width field, enough for 0 to 31
	localparam int N_W = 5;

	// ------------------------------------------------------------------------
	// Encodings
	// ------------------------------------------------------------------------

	// Register map of the slave, word index
	typedef enum logic [1:0] {
		REG_N     = 2'd0,
		REG_VALUE = 2'd1,
		REG_DEST  = 2'd2,
		REG_START = 2'd3
	} reg_sel_e;

	// AXI response codes, only OKAY is driven by the block
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_SLVERR = 2'd2
	} axi_resp_e;

	// Write master FSM
	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR_DATA,
		WR_RESP
	} wr_state_e;

endpackage

`default_nettype wire

// File: rtl/axil_reg_slave.sv
`default_nettype none

module axil_reg_slave
	import mask_pkg::*;
(
	input  wire logic                aclk,
	input  wire logic                aresetn,
	// Write address channel
	input  wire logic [S_ADDR_W-1:0] s_axi_awaddr,
	input  wire logic                s_axi_awvalid,
	output logic                     s_axi_awready,
	// Write data channel
	input  wire logic [DATA_W-1:0]   s_axi_wdata,
	input  wire logic [STRB_W-1:0]   s_axi_wstrb,
	input  wire logic                s_axi_wvalid,
	output logic                     s_axi_wready,
	// Write response channel
	output axi_resp_e                s_axi_bresp,
	output logic                     s_axi_bvalid,
	input  wire logic                s_axi_bready,
	// Read address channel
	input  wire logic [S_ADDR_W-1:0] s_axi_araddr,
	input  wire logic                s_axi_arvalid,
	output logic                     s_axi_arready,
	// Read data channel
	output logic [DATA_W-1:0]        s_axi_rdata,
	output axi_resp_e                s_axi_rresp,
	output logic                     s_axi_rvalid,
	input  wire logic                s_axi_rready,
	// Job request towards the mask stage
	output logic                     start,
	output logic [N_W-1:0]           mask_n,
	output logic [DATA_W-1:0]        value,
	output logic [DATA_W-1:0]        dest
);

	// Register file, REG_START has no storage
	logic [DATA_W-1:0] reg_n;
	logic [DATA_W-1:0] reg_value;
	logic [DATA_W-1:0] reg_dest;

	// Write accepted in this cycle
	logic      wr_en;
	reg_sel_e  wr_sel;
	// Read address accepted in this cycle
	logic      rd_en;
	reg_sel_e  rd_sel;
	logic [DATA_W-1:0] rd_mux;

	// Byte-wise merge of new data into a register
	function automatic logic [DATA_W-1:0] apply_strb(
		input logic [DATA_W-1:0] old_val,
		input logic [DATA_W-1:0] new_val,
		input logic [STRB_W-1:0] strb
	);
		logic [DATA_W-1:0] res;
		res = old_val;
		for (int i = 0; i < STRB_W; i++)
		begin
			if (strb[i])
			begin
				res[i*8 +: 8] = new_val[i*8 +: 8];
			end
		end
		return res;
	endfunction

	// ------------------------------------------------------------------------
	// Write path
	// ------------------------------------------------------------------------

	// AW and W are accepted together, address is stable while valid is high
	assign wr_en  = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;
	assign wr_sel = reg_sel_e'(s_axi_awaddr[ADDR_LSB +: $bits(reg_sel_e)]);

	// One-cycle ready pulse, blocked while a response is pending
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			s_axi_awready <= 1'b0;
			s_axi_wready  <= 1'b0;
		end
		else
		begin
			if (!s_axi_awready && !s_axi_bvalid && s_axi_awvalid && s_axi_wvalid)
			begin
				s_axi_awready <= 1'b1;
				s_axi_wready  <= 1'b1;
			end
			else
			begin
				s_axi_awready <= 1'b0;
				s_axi_wready  <= 1'b0;
			end
		end
	end

	// Register update with byte strobes
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			reg_n     <= '0;
			reg_value <= '0;
			reg_dest  <= '0;
		end
		else if (wr_en)
		begin
			case (wr_sel)
				REG_N:     reg_n     <= apply_strb(reg_n, s_axi_wdata, s_axi_wstrb);
				REG_VALUE: reg_value <= apply_strb(reg_value, s_axi_wdata, s_axi_wstrb);
				REG_DEST:  reg_dest  <= apply_strb(reg_dest, s_axi_wdata, s_axi_wstrb);
				default:   ;
			endcase
		end
	end

	// Response follows the accept cycle and waits for BREADY
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			s_axi_bvalid <= 1'b0;
		end
		else if (wr_en)
		begin
			s_axi_bvalid <= 1'b1;
		end
		else if (s_axi_bready)
		begin
			s_axi_bvalid <= 1'b0;
		end
	end

	assign s_axi_bresp = RESP_OKAY;

	// Start fires in the accept cycle of a REG_START write
	assign start = wr_en && (wr_sel == REG_START) && (|s_axi_wstrb);

	// ------------------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------------------

	assign rd_en  = s_axi_arready && s_axi_arvalid;
	assign rd_sel = reg_sel_e'(s_axi_araddr[ADDR_LSB +: $bits(reg_sel_e)]);

	always_comb
	begin
		case (rd_sel)
			REG_N:     rd_mux = reg_n;
			REG_VALUE: rd_mux = reg_value;
			REG_DEST:  rd_mux = reg_dest;
			// Start register is write-only
			default:   rd_mux = '0;
		endcase
	end

	// Single outstanding read
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			s_axi_arready <= 1'b0;
			s_axi_rvalid  <= 1'b0;
		end
		else
		begin
			s_axi_arready <= !s_axi_arready && !s_axi_rvalid && s_axi_arvalid;
			if (rd_en)
			begin
				s_axi_rvalid <= 1'b1;
			end
			else if (s_axi_rready)
			begin
				s_axi_rvalid <= 1'b0;
			end
		end
	end

	// Read data register
	always_ff @(posedge aclk)
	begin
		if (rd_en)
		begin
			s_axi_rdata <= rd_mux;
		end
	end

	assign s_axi_rresp = RESP_OKAY;

	// Operands to the mask stage
	assign mask_n = reg_n[N_W-1:0];
	assign value  = reg_value;
	assign dest   = reg_dest;

	// Write response held until taken by the host
	a_bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

endmodule

`default_nettype wire

// File: rtl/mask_unit.sv
`default_nettype none

module mask_unit
	import mask_pkg::*;
#(
	parameter int M_ADDR_W = 32
)
(
	input  wire logic              aclk,
	input  wire logic              aresetn,
	// Operands from the register slave
	input  wire logic              start,
	input  wire logic [N_W-1:0]    mask_n,
	input  wire logic [DATA_W-1:0] value,
	input  wire logic [DATA_W-1:0] dest,
	// Job towards the write master
	output logic                   job_valid,
	input  wire logic              job_ready,
	output logic [DATA_W-1:0]      job_data,
	output logic [M_ADDR_W-1:0]    job_addr
);

	// n low ones, all zero for n = 0
	logic [DATA_W-1:0] mask;
	// Stage empty or its job leaves now
	logic              take;

	assign mask = (DATA_W'(1) << mask_n) - DATA_W'(1);
	assign take = start && (!job_valid || job_ready);

	// Occupancy flag, a start into a stuck full stage is lost
	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			job_valid <= 1'b0;
		end
		else if (take)
		begin
			job_valid <= 1'b1;
		end
		else if (job_ready)
		begin
			job_valid <= 1'b0;
		end
	end

	// Job payload snapshot taken at the start cycle
	always_ff @(posedge aclk)
	begin
		if (take)
		begin
			job_data <= value & mask;
			// Zero extend or truncate to the master address width
			job_addr <= M_ADDR_W'(dest);
		end
	end

	a_job_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		job_valid && !job_ready |=> job_valid && $stable(job_data) && $stable(job_addr));

endmodule

`default_nettype wire

// File: rtl/axil_write_master.sv
`default_nettype none

module axil_write_master
	import mask_pkg::*;
#(
	parameter int M_ADDR_W = 32
)
(
	input  wire logic                aclk,
	input  wire logic                aresetn,
	// Job from the mask stage
	input  wire logic                job_valid,
	output logic                     job_ready,
	input  wire logic [DATA_W-1:0]   job_data,
	input  wire logic [M_ADDR_W-1:0] job_addr,
	// Write address channel
	output logic [M_ADDR_W-1:0]      m_axi_awaddr,
	output logic                     m_axi_awvalid,
	input  wire logic                m_axi_awready,
	// Write data channel
	output logic [DATA_W-1:0]        m_axi_wdata,
	output logic [STRB_W-1:0]        m_axi_wstrb,
	output logic                     m_axi_wvalid,
	input  wire logic                m_axi_wready,
	// Write response channel, code accepted whatever its value
	input  axi_resp_e                m_axi_bresp,
	input  wire logic                m_axi_bvalid,
	output logic                     m_axi_bready
);

	wr_state_e state;

	// Channels still waiting after this cycle
	logic aw_pend;
	logic w_pend;

	assign aw_pend = m_axi_awvalid && !m_axi_awready;
	assign w_pend  = m_axi_wvalid && !m_axi_wready;

	// New job only when the previous one is fully answered
	assign job_ready = (state == WR_IDLE);

	// Full word writes
	assign m_axi_wstrb = '1;

	// ------------------------------------------------------------------------
	// Write FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			state         <= WR_IDLE;
			m_axi_awvalid <= 1'b0;
			m_axi_wvalid  <= 1'b0;
			m_axi_bready  <= 1'b0;
		end
		else
		begin
			case (state)
				WR_IDLE:
				begin
					// Both valids go up together
					if (job_valid)
					begin
						m_axi_awvalid <= 1'b1;
						m_axi_wvalid  <= 1'b1;
						state         <= WR_ADDR_DATA;
					end
				end
				WR_ADDR_DATA:
				begin
					// AW and W drop on their own handshakes
					m_axi_awvalid <= aw_pend;
					m_axi_wvalid  <= w_pend;
					if (!aw_pend && !w_pend)
					begin
						m_axi_bready <= 1'b1;
						state        <= WR_RESP;
					end
				end
				WR_RESP:
				begin
					// Job ends with the B handshake
					if (m_axi_bvalid)
					begin
						m_axi_bready <= 1'b0;
						state        <= WR_IDLE;
					end
				end
				default:
				begin
					state <= WR_IDLE;
				end
			endcase
		end
	end

	// Address and data captured with the job
	always_ff @(posedge aclk)
	begin
		if (job_valid && job_ready)
		begin
			m_axi_awaddr <= job_addr;
			m_axi_wdata  <= job_data;
		end
	end

	a_awvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid);

endmodule

`default_nettype wire

// File: rtl/mask_offload_top.sv
`default_nettype none

module mask_offload_top
	import mask_pkg::*;
#(
	parameter int M_ADDR_W = 32
)
(
	input  wire logic                aclk,
	input  wire logic                aresetn,
	// Host side AXI4-Lite slave
	input  wire logic [S_ADDR_W-1:0] s_axi_awaddr,
	input  wire logic                s_axi_awvalid,
	output logic                     s_axi_awready,
	input  wire logic [DATA_W-1:0]   s_axi_wdata,
	input  wire logic [STRB_W-1:0]   s_axi_wstrb,
	input  wire logic                s_axi_wvalid,
	output logic                     s_axi_wready,
	output axi_resp_e                s_axi_bresp,
	output logic                     s_axi_bvalid,
	input  wire logic                s_axi_bready,
	input  wire logic [S_ADDR_W-1:0] s_axi_araddr,
	input  wire logic                s_axi_arvalid,
	output logic                     s_axi_arready,
	output logic [DATA_W-1:0]        s_axi_rdata,
	output axi_resp_e                s_axi_rresp,
	output logic                     s_axi_rvalid,
	input  wire logic                s_axi_rready,
	// Memory side AXI4-Lite master, write only
	output logic [M_ADDR_W-1:0]      m_axi_awaddr,
	output logic                     m_axi_awvalid,
	input  wire logic                m_axi_awready,
	output logic [DATA_W-1:0]        m_axi_wdata,
	output logic [STRB_W-1:0]        m_axi_wstrb,
	output logic                     m_axi_wvalid,
	input  wire logic                m_axi_wready,
	input  axi_resp_e                m_axi_bresp,
	input  wire logic                m_axi_bvalid,
	output logic                     m_axi_bready
);

	// Register slave to mask stage
	logic              start;
	logic [N_W-1:0]    mask_n;
	logic [DATA_W-1:0] value;
	logic [DATA_W-1:0] dest;

	// Mask stage to write master
	logic                job_valid;
	logic                job_ready;
	logic [DATA_W-1:0]   job_data;
	logic [M_ADDR_W-1:0] job_addr;

	// ------------------------------------------------------------------------
	// Stage 1, register slave
	// ------------------------------------------------------------------------

	axil_reg_slave u_reg_slave (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.start         (start),
		.mask_n        (mask_n),
		.value         (value),
		.dest          (dest)
	);

	// Stage 2, mask and hold one job
	mask_unit #(
		.M_ADDR_W (M_ADDR_W)
	) u_mask_unit (
		.aclk      (aclk),
		.aresetn   (aresetn),
		.start     (start),
		.mask_n    (mask_n),
		.value     (value),
		.dest      (dest),
		.job_valid (job_valid),
		.job_ready (job_ready),
		.job_data  (job_data),
		.job_addr  (job_addr)
	);

	// Stage 3, single-beat write out
	axil_write_master #(
		.M_ADDR_W (M_ADDR_W)
	) u_write_master (
		.aclk          (aclk),
		.aresetn       (aresetn),
		.job_valid     (job_valid),
		.job_ready     (job_ready),
		.job_data      (job_data),
		.job_addr      (job_addr),
		.m_axi_awaddr  (m_axi_awaddr),
		.m_axi_awvalid (m_axi_awvalid),
		.m_axi_awready (m_axi_awready),
		.m_axi_wdata   (m_axi_wdata),
		.m_axi_wstrb   (m_axi_wstrb),
		.m_axi_wvalid  (m_axi_wvalid),
		.m_axi_wready  (m_axi_wready),
		.m_axi_bresp   (m_axi_bresp),
		.m_axi_bvalid  (m_axi_bvalid),
		.m_axi_bready  (m_axi_bready)
	);

endmodule

`default_nettype wire

// File: verif/tb_mask_funcs.svh
`ifndef TB_MASK_FUNCS_SVH
`define TB_MASK_FUNCS_SVH

// ------------------------------------------------------------------------
// Stimulus and reference helpers
// ------------------------------------------------------------------------

// Next state of a 32-bit linear congruential generator
function automatic logic [31:0] lcg_next(input logic [31:0] state);
	return state * 32'd1664525 + 32'd1013904223;
endfunction

// Expected master data, bit i survives only while i is below n
function automatic logic [31:0] ref_mask(input logic [31:0] val, input logic [4:0] n);
	logic [31:0] res;
	int          width;
	width = {27'd0, n};
	res = '0;
	for (int i = 0; i < 32; i++)
	begin
		if (i < width)
		begin
			res[i] = val[i];
		end
	end
	return res;
endfunction

// Register contents after a host write, one strobe bit per byte lane
function automatic logic [31:0] strb_merge(
	input logic [31:0] old_val,
	input logic [31:0] new_val,
	input logic [3:0]  strb
);
	logic [31:0] lanes;
	lanes = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
	return (old_val & ~lanes) | (new_val & lanes);
endfunction

`endif

// File: verif/tb_mask_offload.sv
`default_nettype none

module tb_mask_offload
	import mask_pkg::*;
();

	localparam int          CLK_PERIOD = 20;
	localparam logic [31:0] SEED       = 32'h8a6e7ea2;
	localparam int          N_RANDOM   = 60;
	// Each random job is four host writes plus one master write
	localparam int          N_PLANNED  = N_RANDOM * 5 + 50;
	localparam int          WATCHDOG_CYCLES = 200 * N_PLANNED;

	`include "tb_mask_funcs.svh"

	logic              aclk;
	logic              aresetn;
	logic [3:0]        s_axi_awaddr;
	logic              s_axi_awvalid;
	logic              s_axi_awready;
	logic [31:0]       s_axi_wdata;
	logic [3:0]        s_axi_wstrb;
	logic              s_axi_wvalid;
	logic              s_axi_wready;
	axi_resp_e         s_axi_bresp;
	logic              s_axi_bvalid;
	logic              s_axi_bready;
	logic [3:0]        s_axi_araddr;
	logic              s_axi_arvalid;
	logic              s_axi_arready;
	logic [31:0]       s_axi_rdata;
	axi_resp_e         s_axi_rresp;
	logic              s_axi_rvalid;
	logic              s_axi_rready;
	logic [31:0]       m_axi_awaddr;
	logic              m_axi_awvalid;
	logic              m_axi_awready;
	logic [31:0]       m_axi_wdata;
	logic [3:0]        m_axi_wstrb;
	logic              m_axi_wvalid;
	logic              m_axi_wready;
	axi_resp_e         m_axi_bresp;
	logic              m_axi_bvalid;
	logic              m_axi_bready;

	// Sink mode 0 is always ready, 1 stalls at random, 2 blocks AW and W
	int          sink_mode = 0;
	// Completed B handshakes on the master port
	int          b_count = 0;
	int          compare_errors = 0;
	int          check_errors = 0;
	logic [31:0] stim_state = SEED;
	// Shadow of registers 0 to 2
	logic [31:0] reg_model [4];

	// Expected and observed master writes
	logic [31:0] exp_addr [$];
	logic [31:0] exp_data [$];
	logic [31:0] got_addr [$];
	logic [31:0] got_data [$];
	logic [3:0]  got_strb [$];

	mask_offload_top #(.M_ADDR_W(32)) uut (.*);

	initial
	begin
		aclk = 1'b0;
		forever #(CLK_PERIOD / 2) aclk = ~aclk;
	end

	// ------------------------------------------------------------------------
	// Memory side sink
	// ------------------------------------------------------------------------

	initial
	begin
		logic [31:0] sink_state;
		logic        aw_seen;
		logic        w_seen;
		logic        b_pend;
		logic [31:0] aw_addr_s;
		logic [31:0] w_data_s;
		logic [3:0]  w_strb_s;
		sink_state = ~SEED;
		aw_seen = 1'b0;
		w_seen = 1'b0;
		b_pend = 1'b0;
		m_axi_awready <= 1'b0;
		m_axi_wready  <= 1'b0;
		m_axi_bvalid  <= 1'b0;
		m_axi_bresp   <= RESP_OKAY;
		forever
		begin
			@(posedge aclk);
			sink_state = lcg_next(sink_state);
			if (!aresetn)
			begin
				aw_seen = 1'b0;
				w_seen = 1'b0;
				b_pend = 1'b0;
				m_axi_awready <= 1'b0;
				m_axi_wready  <= 1'b0;
				m_axi_bvalid  <= 1'b0;
			end
			else
			begin
				// Handshakes of the cycle that just ended
				if (m_axi_awvalid && m_axi_awready)
				begin
					aw_seen = 1'b1;
					aw_addr_s = m_axi_awaddr;
				end
				if (m_axi_wvalid && m_axi_wready)
				begin
					w_seen = 1'b1;
					w_data_s = m_axi_wdata;
					w_strb_s = m_axi_wstrb;
				end
				if (m_axi_bvalid && m_axi_bready)
				begin
					m_axi_bvalid <= 1'b0;
					b_pend = 1'b0;
					b_count++;
				end
				else if (b_pend && !m_axi_bvalid && (sink_mode != 1 || sink_state[20]))
				begin
					m_axi_bvalid <= 1'b1;
				end
				// Log the write and owe a response once both halves are in
				if (aw_seen && w_seen && !b_pend)
				begin
					got_addr.push_back(aw_addr_s);
					got_data.push_back(w_data_s);
					got_strb.push_back(w_strb_s);
					b_pend = 1'b1;
					aw_seen = 1'b0;
					w_seen = 1'b0;
				end
				m_axi_awready <= (sink_mode == 0) || (sink_mode == 1 && sink_state[9]);
				m_axi_wready  <= (sink_mode == 0) || (sink_mode == 1 && sink_state[14]);
			end
		end
	end

	// Compare observed writes with the expected ones at mid-cycle
	initial
	begin
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [31:0] exp_a;
		logic [31:0] exp_d;
		forever
		begin
			@(negedge aclk);
			while (got_addr.size() > 0)
			begin
				addr = got_addr.pop_front();
				data = got_data.pop_front();
				strb = got_strb.pop_front();
				assert (exp_addr.size() > 0) else
				begin
					compare_errors++;
					$display("Unexpected master write to address %h with data %h", addr, data);
				end
				if (exp_addr.size() > 0)
				begin
					exp_a = exp_addr.pop_front();
					exp_d = exp_data.pop_front();
					assert (addr == exp_a) else
					begin
						compare_errors++;
						$display("MISMATCH m_axi_awaddr got %h expected %h", addr, exp_a);
					end
					assert (data == exp_d) else
					begin
						compare_errors++;
						$display("MISMATCH m_axi_wdata got %h expected %h", data, exp_d);
					end
					assert (strb == 4'hf) else
					begin
						compare_errors++;
						$display("MISMATCH m_axi_wstrb got %h expected %h", strb, 4'hf);
					end
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Host tasks on the slave port
	// ------------------------------------------------------------------------

	task automatic host_write(input reg_sel_e sel, input logic [31:0] data, input logic [3:0] strb);
		@(posedge aclk);
		s_axi_awaddr  <= {sel, 2'b00};
		s_axi_awvalid <= 1'b1;
		s_axi_wdata   <= data;
		s_axi_wstrb   <= strb;
		s_axi_wvalid  <= 1'b1;
		// AW and W are taken together
		@(posedge aclk);
		while (!(s_axi_awready && s_axi_wready))
		begin
			@(posedge aclk);
		end
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid  <= 1'b0;
		s_axi_bready  <= 1'b1;
		@(posedge aclk);
		while (!s_axi_bvalid)
		begin
			@(posedge aclk);
		end
		assert (s_axi_bresp == RESP_OKAY) else
		begin
			check_errors++;
			$display("MISMATCH s_axi_bresp got %h expected %h", s_axi_bresp, RESP_OKAY);
		end
		s_axi_bready <= 1'b0;
	endtask

	task automatic check_read(input reg_sel_e sel, input logic [31:0] expected);
		@(posedge aclk);
		s_axi_araddr  <= {sel, 2'b00};
		s_axi_arvalid <= 1'b1;
		@(posedge aclk);
		while (!s_axi_arready)
		begin
			@(posedge aclk);
		end
		s_axi_arvalid <= 1'b0;
		s_axi_rready  <= 1'b1;
		@(posedge aclk);
		while (!s_axi_rvalid)
		begin
			@(posedge aclk);
		end
		assert (s_axi_rdata == expected) else
		begin
			check_errors++;
			$display("MISMATCH s_axi_rdata got %h expected %h", s_axi_rdata, expected);
		end
		assert (s_axi_rresp == RESP_OKAY) else
		begin
			check_errors++;
			$display("MISMATCH s_axi_rresp got %h expected %h", s_axi_rresp, RESP_OKAY);
		end
		s_axi_rready <= 1'b0;
	endtask

	// Host write that also updates the shadow registers
	task automatic write_model(input reg_sel_e sel, input logic [31:0] data, input logic [3:0] strb);
		host_write(sel, data, strb);
		reg_model[sel] = strb_merge(reg_model[sel], data, strb);
	endtask

	// Load the operands, queue the expected write and fire start
	task automatic start_job(input logic [4:0] n, input logic [31:0] val, input logic [31:0] dst);
		host_write(REG_N, {27'd0, n}, 4'hf);
		host_write(REG_VALUE, val, 4'hf);
		host_write(REG_DEST, dst, 4'hf);
		exp_addr.push_back(dst);
		exp_data.push_back(ref_mask(val, n));
		host_write(REG_START, 32'h1, 4'h1);
	endtask

	// Wait until the master B handshakes reach a total or time out
	task automatic wait_writes(input int target);
		int cycles;
		cycles = 0;
		while (b_count < target && cycles < 400)
		begin
			@(negedge aclk);
			cycles++;
		end
		assert (b_count >= target) else
		begin
			check_errors++;
			$display("Master write missing, %0d of %0d responses seen", b_count, target);
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial
	begin
		int          jobs;
		logic [4:0]  n;
		logic [31:0] val;
		logic [31:0] dst;
		jobs = 0;
		reg_model[0] = '0;
		reg_model[1] = '0;
		reg_model[2] = '0;
		reg_model[3] = '0;
		aresetn       <= 1'b0;
		s_axi_awaddr  <= '0;
		s_axi_awvalid <= 1'b0;
		s_axi_wdata   <= '0;
		s_axi_wstrb   <= '0;
		s_axi_wvalid  <= 1'b0;
		s_axi_bready  <= 1'b0;
		s_axi_araddr  <= '0;
		s_axi_arvalid <= 1'b0;
		s_axi_rready  <= 1'b0;
		repeat (5) @(posedge aclk);
		aresetn <= 1'b1;

		// All registers clear and nothing on the master port
		check_read(REG_N, 32'h0);
		check_read(REG_VALUE, 32'h0);
		check_read(REG_DEST, 32'h0);
		check_read(REG_START, 32'h0);

		// Partial strobes merge byte lanes
		write_model(REG_N, 32'ha1b2c3d4, 4'b0101);
		write_model(REG_VALUE, 32'h11223344, 4'b1000);
		write_model(REG_VALUE, 32'h55667788, 4'b0011);
		write_model(REG_DEST, 32'hcafef00d, 4'b1110);
		// No strobe on the start register means no job
		host_write(REG_START, 32'hffffffff, 4'b0000);
		check_read(REG_N, reg_model[0]);
		check_read(REG_VALUE, reg_model[1]);
		check_read(REG_DEST, reg_model[2]);
		check_read(REG_START, 32'h0);
		repeat (20) @(negedge aclk);
		assert (b_count == 0) else
		begin
			check_errors++;
			$display("Master write issued without a start");
		end

		// Directed jobs including both ends of n
		start_job(5'd8, 32'hdeadbeef, 32'h00001000);
		jobs++;
		wait_writes(jobs);
		start_job(5'd0, 32'hffffffff, 32'h00002004);
		jobs++;
		wait_writes(jobs);
		start_job(5'd31, 32'hffffffff, 32'h80000ffc);
		jobs++;
		wait_writes(jobs);

		// Random jobs against a stalling sink
		sink_mode <= 1;
		for (int j = 0; j < N_RANDOM; j++)
		begin
			stim_state = lcg_next(stim_state);
			n = stim_state[31:27];
			stim_state = lcg_next(stim_state);
			val = stim_state;
			stim_state = lcg_next(stim_state);
			dst = stim_state;
			start_job(n, val, dst);
			jobs++;
			wait_writes(jobs);
		end

		// Two jobs in flight while the master is held in AW and W
		sink_mode <= 2;
		start_job(5'd12, 32'h13579bdf, 32'h00004000);
		start_job(5'd20, 32'h2468ace0, 32'h00005000);
		// Operands change after both starts
		host_write(REG_VALUE, 32'h0, 4'hf);
		host_write(REG_DEST, 32'hffffffff, 4'hf);
		// First job still offered on the blocked AW and W channels
		@(negedge aclk);
		assert (m_axi_awvalid && m_axi_wvalid) else
		begin
			check_errors++;
			$display("Master not offering AW and W while the sink blocks them");
		end
		sink_mode <= 0;
		jobs = jobs + 2;
		wait_writes(jobs);

		// Operand rewrite right after a start
		start_job(5'd16, 32'habcdef01, 32'h00006000);
		host_write(REG_VALUE, 32'h0f0f0f0f, 4'hf);
		host_write(REG_N, 32'h1f, 4'hf);
		jobs++;
		wait_writes(jobs);

		repeat (20) @(negedge aclk);
		assert (exp_addr.size() == 0) else
		begin
			check_errors++;
			$display("%0d expected master writes never appeared", exp_addr.size());
		end
		$display("Errors: compare %0d, host %0d", compare_errors, check_errors);
		if (compare_errors == 0 && check_errors == 0)
		begin
			$display(">>> PASS");
		end
		else
		begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog sized from the planned transactions
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge aclk);
		$display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
		$display("Errors: compare %0d, host %0d", compare_errors, check_errors);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+verif
rtl/mask_pkg.sv
rtl/axil_reg_slave.sv
rtl/mask_unit.sv
rtl/axil_write_master.sv
rtl/mask_offload_top.sv
verif/tb_mask_offload.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --assert -j 0
TOP       ?= tb_mask_offload
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJDIR)
